//--- common/l1d_pkg.sv
package l1d_pkg;

  // --------------------------------------------------
  // Cache geometry
  // --------------------------------------------------
  localparam int LINE_W = 128;
  localparam int WORD_W = 32;
  localparam int BEATS  = 4;
  localparam int SETS   = 16;

  // Address field positions
  localparam int WORD_LSB = 2;
  localparam int IDX_LSB  = 4;
  localparam int TAG_LSB  = 8;

  typedef logic [31:0]       paddr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [3:0]        index_t;
  typedef logic [23:0]       tag_t;
  typedef logic [3:0]        be_t;
  typedef logic [1:0]        beat_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    STATUS_NONE,
    STATUS_HIT,
    STATUS_MISS,
    STATUS_L1D_CONFLICT
  } l1d_status_e;

  typedef enum logic {
    L2_CMD_RD,
    L2_CMD_WR
  } l2_cmd_e;

  // Write-back comes before the refill read
  typedef enum logic [2:0] {
    MISS_IDLE,
    MISS_EVICT,
    MISS_REFILL_REQ,
    MISS_REFILL_WAIT,
    MISS_FILL
  } miss_state_e;

endpackage

//--- dcache/l1d_data_array.sv
`timescale 1ns/100ps

module l1d_data_array (
  input  logic            i_clk,
  input  logic            i_reset_n,

  // Read port A, load and store lookup
  input  l1d_pkg::index_t i_rd_a_index,
  output l1d_pkg::tag_t   o_rd_a_tag,
  output logic            o_rd_a_valid,
  output logic            o_rd_a_dirty,
  output l1d_pkg::line_t  o_rd_a_line,

  // Read port B, snoop
  input  l1d_pkg::index_t i_rd_b_index,
  output l1d_pkg::tag_t   o_rd_b_tag,
  output logic            o_rd_b_valid,
  output l1d_pkg::line_t  o_rd_b_line,

  // Store word write
  input  logic            i_st_we,
  input  l1d_pkg::index_t i_st_index,
  input  l1d_pkg::beat_t  i_st_word,
  input  l1d_pkg::word_t  i_st_data,
  input  l1d_pkg::be_t    i_st_be,

  // Refill line write
  input  logic            i_fill_we,
  input  l1d_pkg::index_t i_fill_index,
  input  l1d_pkg::tag_t   i_fill_tag,
  input  l1d_pkg::line_t  i_fill_line
);
  import l1d_pkg::*;

  tag_t            r_tag  [SETS];
  line_t           r_data [SETS];
  logic [SETS-1:0] r_valid;
  logic [SETS-1:0] r_dirty;

  assign o_rd_a_tag   = r_tag[i_rd_a_index];
  assign o_rd_a_valid = r_valid[i_rd_a_index];
  assign o_rd_a_dirty = r_dirty[i_rd_a_index];
  assign o_rd_a_line  = r_data[i_rd_a_index];

  assign o_rd_b_tag   = r_tag[i_rd_b_index];
  assign o_rd_b_valid = r_valid[i_rd_b_index];
  assign o_rd_b_line  = r_data[i_rd_b_index];

  // Line state bits
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_dirty <= '0;
    end else if (i_fill_we) begin
      r_valid[i_fill_index] <= 1'b1;
      r_dirty[i_fill_index] <= 1'b0;
    end else if (i_st_we) begin
      r_dirty[i_st_index] <= 1'b1;
    end
  end

  // Tag and data storage, store merges only the enabled bytes
  always_ff @(posedge i_clk) begin
    if (i_fill_we) begin
      r_tag[i_fill_index]  <= i_fill_tag;
      r_data[i_fill_index] <= i_fill_line;
    end else if (i_st_we) begin
      for (int b = 0; b < WORD_W / 8; b++) begin
        if (i_st_be[b]) begin
          r_data[i_st_index][int'(i_st_word) * WORD_W + b * 8 +: 8] <= i_st_data[b * 8 +: 8];
        end
      end
    end
  end

endmodule

//--- dcache/l1d_miss_fsm.sv
`timescale 1ns/100ps

module l1d_miss_fsm (
  input  logic                i_clk,
  input  logic                i_reset_n,

  // Miss request with the victim seen on read port A
  input  logic                i_miss_start,
  input  l1d_pkg::paddr_t     i_miss_paddr,
  input  logic                i_victim_valid,
  input  logic                i_victim_dirty,
  input  l1d_pkg::tag_t       i_victim_tag,
  input  l1d_pkg::line_t      i_victim_line,

  output logic                o_busy,
  output l1d_pkg::index_t     o_busy_index,
  output l1d_pkg::tag_t       o_busy_tag,

  // L2 request channel
  output logic                o_l2_req_valid,
  input  logic                i_l2_req_ready,
  output l1d_pkg::l2_cmd_e    o_l2_req_cmd,
  output l1d_pkg::paddr_t     o_l2_req_paddr,
  output l1d_pkg::line_t      o_l2_req_data,

  input  logic                i_line_done,

  output logic                o_count_start,
  output logic                o_fill_we,
  output logic                o_refill_valid,
  output l1d_pkg::paddr_t     o_refill_paddr
);
  import l1d_pkg::*;

  miss_state_e r_state;
  miss_state_e w_state_next;
  index_t      r_index;
  tag_t        r_tag;
  tag_t        r_victim_tag;
  line_t       r_victim_line;
  logic        w_req_fire;

  assign w_req_fire = o_l2_req_valid & i_l2_req_ready;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      MISS_IDLE: begin
        if (i_miss_start) begin
          // Clean or empty victim goes straight to the read
          w_state_next = (i_victim_valid & i_victim_dirty) ? MISS_EVICT : MISS_REFILL_REQ;
        end
      end
      MISS_EVICT:       if (w_req_fire) w_state_next = MISS_REFILL_REQ;
      MISS_REFILL_REQ:  if (w_req_fire) w_state_next = MISS_REFILL_WAIT;
      MISS_REFILL_WAIT: if (i_line_done) w_state_next = MISS_FILL;
      MISS_FILL:        w_state_next = MISS_IDLE;
      default:          w_state_next = MISS_IDLE;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= MISS_IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  // Capture miss line and victim when a refill begins
  always_ff @(posedge i_clk) begin
    if (i_miss_start && r_state == MISS_IDLE) begin
      r_index       <= i_miss_paddr[TAG_LSB-1:IDX_LSB];
      r_tag         <= i_miss_paddr[31:TAG_LSB];
      r_victim_tag  <= i_victim_tag;
      r_victim_line <= i_victim_line;
    end
  end

  assign o_busy       = (r_state != MISS_IDLE);
  assign o_busy_index = r_index;
  assign o_busy_tag   = r_tag;

  // --------------------------------------------------
  // L2 request, held stable until accepted
  // --------------------------------------------------
  assign o_l2_req_valid = (r_state == MISS_EVICT) | (r_state == MISS_REFILL_REQ);
  assign o_l2_req_cmd   = (r_state == MISS_EVICT) ? L2_CMD_WR : L2_CMD_RD;
  assign o_l2_req_paddr = (r_state == MISS_EVICT) ? {r_victim_tag, r_index, {IDX_LSB{1'b0}}} :
                                                    {r_tag, r_index, {IDX_LSB{1'b0}}};
  assign o_l2_req_data  = r_victim_line;

  assign o_count_start  = (r_state == MISS_REFILL_REQ) & w_req_fire;
  assign o_fill_we      = (r_state == MISS_FILL);
  assign o_refill_valid = (r_state == MISS_FILL);
  assign o_refill_paddr = {r_tag, r_index, {IDX_LSB{1'b0}}};

endmodule

//--- project.f
common/l1d_pkg.sv
verilog/l1d_refill_beat_counter.sv
dcache/l1d_data_array.sv
dcache/l1d_miss_fsm.sv
verilog/l1d_top.sv
testbench/l1d_top_props.sv
testbench/tb_l1d_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the L1D testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_l1d_top \
  -Mdir obj_dir -o sim_l1d
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_l1d)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'ALL TESTS PASSED'; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- testbench/l1d_top_props.sv
`timescale 1ns/100ps

module l1d_top_props (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_ld_valid,
  input logic             i_st_valid,
  input logic             i_snoop_valid,
  input logic             i_ld_resp_valid,
  input logic             i_st_resp_valid,
  input logic             i_snoop_resp_valid,
  input logic             i_l2_req_valid,
  input logic             i_l2_req_ready,
  input l1d_pkg::l2_cmd_e i_l2_req_cmd,
  input l1d_pkg::paddr_t  i_l2_req_paddr,
  input l1d_pkg::line_t   i_l2_req_data,
  input logic             i_refill_valid
);

  // --------------------------------------------------
  // L2 handshake
  // --------------------------------------------------
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req_valid && !i_l2_req_ready |=> i_l2_req_valid && $stable(i_l2_req_cmd) &&
      $stable(i_l2_req_paddr) && $stable(i_l2_req_data))
    else $error("L2 request dropped or changed before ready");

  a_refill_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_refill_valid |=> !i_refill_valid)
    else $error("Refill valid held longer than one cycle");

  // Fixed one cycle s0 to s1
  a_resp_timing: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_ld_resp_valid == $past(i_ld_valid)) && (i_st_resp_valid == $past(i_st_valid)) &&
      (i_snoop_resp_valid == $past(i_snoop_valid)))
    else $error("Response valid not one cycle after its request");

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> !i_l2_req_valid && !i_refill_valid && !i_ld_resp_valid)
    else $error("Outputs active during reset");

endmodule

//--- testbench/l1d_trace.txt
# Columns: test name, op, address, store data, byte enables, expected status, expected data
# Ops: LD load, ST store, SN snoop, RF wait for refill of the line at address, QT no refill pulse
ld_empty_miss       LD 00001040 00000000 0 MISS 0
ld_empty_refill     RF 00001040 00000000 0 NONE 0
ld_after_fill       LD 00001044 00000000 0 HIT  FFFF1044
ld_after_fill_w0    LD 00001040 00000000 0 HIT  FFFF1040
hi_ld_miss          LD 8765A3F4 00000000 0 MISS 0
hi_refill           RF 8765A3F0 00000000 0 NONE 0
hi_ld_hit           LD 8765A3F4 00000000 0 HIT  789AA3F4
st_hit              ST 00001048 AABBCCDD 5 HIT  0
ld_after_st_hit     LD 00001048 00000000 0 HIT  FFBB10DD
st_miss             ST 00002080 12345678 F MISS 0
st_miss_ld          LD 00002080 00000000 0 MISS 0
st_miss_refill      RF 00002080 00000000 0 NONE 0
st_miss_unchanged   LD 00002080 00000000 0 HIT  FFFF2080
busy_ld_miss        LD 000030C0 00000000 0 MISS 0
busy_ld_conflict    LD 000040D0 00000000 0 CONF 0
busy_st_conflict    ST 00001040 55555555 F CONF 0
busy_refill         RF 000030C0 00000000 0 NONE 0
busy_single_pulse   QT 00000000 00000000 0 NONE 0
busy_st_not_written LD 00001040 00000000 0 HIT  FFFF1040
busy_refilled_line  LD 000030C4 00000000 0 HIT  FFFF30C4
evict_ld_miss       LD 00005040 00000000 0 MISS 0
evict_refill        RF 00005040 00000000 0 NONE 0
evict_ld_new        LD 0000504C 00000000 0 HIT  FFFF504C
evict_ld_old_miss   LD 00001048 00000000 0 MISS 0
evict_old_refill    RF 00001040 00000000 0 NONE 0
evict_ld_written    LD 00001048 00000000 0 HIT  FFBB10DD
snoop_hit           SN 00001040 00000000 0 HIT  FFFF104CFFBB10DDFFFF1044FFFF1040
snoop_miss_tag      SN 00005040 00000000 0 MISS 0
snoop_miss_empty    SN 00007000 00000000 0 MISS 0
snoop_no_refill     QT 00000000 00000000 0 NONE 0

//--- testbench/tb_l1d_top.sv
`timescale 1ns/100ps

module tb_l1d_top;
  import l1d_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int QUIET_CYCLES   = 20;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_ld_valid;
  paddr_t              i_ld_paddr;
  logic                o_ld_resp_valid;
  l1d_status_e         o_ld_resp_status;
  word_t               o_ld_resp_data;
  logic                i_st_valid;
  paddr_t              i_st_paddr;
  word_t               i_st_data;
  be_t                 i_st_be;
  logic                o_st_resp_valid;
  l1d_status_e         o_st_resp_status;
  logic                i_snoop_valid;
  paddr_t              i_snoop_paddr;
  logic                o_snoop_resp_valid;
  l1d_status_e         o_snoop_resp_status;
  line_t               o_snoop_resp_data;
  logic [LINE_W/8-1:0] o_snoop_resp_be;
  logic                o_refill_valid;
  paddr_t              o_refill_paddr;
  logic                o_l2_req_valid;
  logic                i_l2_req_ready;
  l2_cmd_e             o_l2_req_cmd;
  paddr_t              o_l2_req_paddr;
  line_t               o_l2_req_data;
  logic                i_l2_resp_valid;
  word_t               i_l2_resp_data;

  // Sparse L2 backing store by byte address
  word_t  mem [paddr_t];
  int     tests        = 0;
  int     passed       = 0;
  int     fails        = 0;
  int     refill_count = 0;
  int     refill_seen  = 0;
  paddr_t refill_paddr = '0;

  l1d_top l1d_top_inst (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_ld_valid          (i_ld_valid),
    .i_ld_paddr          (i_ld_paddr),
    .o_ld_resp_valid     (o_ld_resp_valid),
    .o_ld_resp_status    (o_ld_resp_status),
    .o_ld_resp_data      (o_ld_resp_data),
    .i_st_valid          (i_st_valid),
    .i_st_paddr          (i_st_paddr),
    .i_st_data           (i_st_data),
    .i_st_be             (i_st_be),
    .o_st_resp_valid     (o_st_resp_valid),
    .o_st_resp_status    (o_st_resp_status),
    .i_snoop_valid       (i_snoop_valid),
    .i_snoop_paddr       (i_snoop_paddr),
    .o_snoop_resp_valid  (o_snoop_resp_valid),
    .o_snoop_resp_status (o_snoop_resp_status),
    .o_snoop_resp_data   (o_snoop_resp_data),
    .o_snoop_resp_be     (o_snoop_resp_be),
    .o_refill_valid      (o_refill_valid),
    .o_refill_paddr      (o_refill_paddr),
    .o_l2_req_valid      (o_l2_req_valid),
    .i_l2_req_ready      (i_l2_req_ready),
    .o_l2_req_cmd        (o_l2_req_cmd),
    .o_l2_req_paddr      (o_l2_req_paddr),
    .o_l2_req_data       (o_l2_req_data),
    .i_l2_resp_valid     (i_l2_resp_valid),
    .i_l2_resp_data      (i_l2_resp_data)
  );

  bind l1d_top l1d_top_props l1d_top_props_inst (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_ld_valid         (i_ld_valid),
    .i_st_valid         (i_st_valid),
    .i_snoop_valid      (i_snoop_valid),
    .i_ld_resp_valid    (o_ld_resp_valid),
    .i_st_resp_valid    (o_st_resp_valid),
    .i_snoop_resp_valid (o_snoop_resp_valid),
    .i_l2_req_valid     (o_l2_req_valid),
    .i_l2_req_ready     (i_l2_req_ready),
    .i_l2_req_cmd       (o_l2_req_cmd),
    .i_l2_req_paddr     (o_l2_req_paddr),
    .i_l2_req_data      (o_l2_req_data),
    .i_refill_valid     (o_refill_valid)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // Resolve pulses counted mid-cycle
  always @(negedge i_clk) begin
    if (o_refill_valid) begin
      refill_count <= refill_count + 1;
      refill_paddr <= o_refill_paddr;
    end
  end

  // Untouched words read as their address with the upper half inverted
  function automatic word_t mem_word(paddr_t a);
    if (mem.exists(a)) return mem[a];
    return {~a[31:16], a[15:0]};
  endfunction

  // --------------------------------------------------
  // L2 model driving ready and beats on falling edges
  // --------------------------------------------------
  task automatic run_l2_model();
    int      ready_delay;
    int      beat_gap;
    int      beats_left;
    int      w;
    paddr_t  beat_addr;
    l2_cmd_e req_cmd;
    paddr_t  req_addr;
    line_t   req_data;
    i_l2_req_ready  = 1'b0;
    i_l2_resp_valid = 1'b0;
    i_l2_resp_data  = '0;
    ready_delay = $urandom_range(3, 0);
    beat_gap    = 0;
    beats_left  = 0;
    beat_addr   = '0;
    req_cmd     = L2_CMD_RD;
    req_addr    = '0;
    req_data    = '0;
    forever begin
      @(negedge i_clk);
      i_l2_resp_valid = 1'b0;
      if (i_l2_req_ready) begin
        // Valid was already high, so the last rising edge took it
        i_l2_req_ready = 1'b0;
        ready_delay    = $urandom_range(3, 0);
        if (req_cmd == L2_CMD_WR) begin
          for (w = 0; w < BEATS; w++) begin
            mem[req_addr + paddr_t'(4 * w)] = req_data[w * WORD_W +: WORD_W];
          end
        end else begin
          beats_left = BEATS;
          beat_addr  = req_addr;
          beat_gap   = $urandom_range(2, 0);
        end
      end else if (o_l2_req_valid) begin
        if (ready_delay == 0) begin
          i_l2_req_ready = 1'b1;
          req_cmd        = o_l2_req_cmd;
          req_addr       = o_l2_req_paddr;
          req_data       = o_l2_req_data;
        end else begin
          ready_delay--;
        end
      end
      if (beats_left > 0) begin
        if (beat_gap == 0) begin
          i_l2_resp_valid = 1'b1;
          i_l2_resp_data  = mem_word(beat_addr);
          beat_addr       = beat_addr + 32'd4;
          beats_left--;
          beat_gap = $urandom_range(2, 0);
        end else begin
          beat_gap--;
        end
      end
    end
  endtask

  // Port 0 load, 1 store, 2 snoop
  task automatic await_response(input int port, input string name, output bit seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
      @(negedge i_clk);
      i_ld_valid    = 1'b0;
      i_st_valid    = 1'b0;
      i_snoop_valid = 1'b0;
      case (port)
        0:       seen = o_ld_resp_valid;
        1:       seen = o_st_resp_valid;
        default: seen = o_snoop_resp_valid;
      endcase
    end
    if (!seen) $display("%s: no response within %0d cycles", name, TIMEOUT_CYCLES);
  endtask

  task automatic compare_status(input string name, input l1d_status_e exp,
                                input l1d_status_e act, inout int errs);
    assert (act == exp) else begin
      $display("Mismatch %s: status expected %s actual %s", name, exp.name(), act.name());
      errs++;
    end
  endtask

  task automatic compare_value(input string name, input string what, input line_t exp,
                               input line_t act, inout int errs);
    assert (act == exp) else begin
      $display("Mismatch %s: %s expected %0h actual %0h", name, what, exp, act);
      errs++;
    end
  endtask

  // --------------------------------------------------
  // One trace line
  // --------------------------------------------------
  task automatic run_test(input string name, input string op, input paddr_t addr,
                          input word_t st_data, input be_t st_be, input string exp_st,
                          input line_t exp_data);
    int          errs;
    int          n;
    bit          seen;
    l1d_status_e exp_status;
    errs       = 0;
    exp_status = STATUS_NONE;
    case (exp_st)
      "NONE":  exp_status = STATUS_NONE;
      "HIT":   exp_status = STATUS_HIT;
      "MISS":  exp_status = STATUS_MISS;
      "CONF":  exp_status = STATUS_L1D_CONFLICT;
      default: begin
        $display("%s: unknown status %s in the trace", name, exp_st);
        errs++;
      end
    endcase
    case (op)
      "LD": begin
        i_ld_valid = 1'b1;
        i_ld_paddr = addr;
        await_response(0, name, seen);
        if (!seen) errs++;
        else begin
          compare_status(name, exp_status, o_ld_resp_status, errs);
          if (exp_status == STATUS_HIT) begin
            compare_value(name, "load data", line_t'(exp_data[WORD_W-1:0]),
                          line_t'(o_ld_resp_data), errs);
          end
        end
      end
      "ST": begin
        i_st_valid = 1'b1;
        i_st_paddr = addr;
        i_st_data  = st_data;
        i_st_be    = st_be;
        await_response(1, name, seen);
        if (!seen) errs++;
        else compare_status(name, exp_status, o_st_resp_status, errs);
      end
      "SN": begin
        i_snoop_valid = 1'b1;
        i_snoop_paddr = addr;
        await_response(2, name, seen);
        if (!seen) errs++;
        else begin
          compare_status(name, exp_status, o_snoop_resp_status, errs);
          if (exp_status == STATUS_HIT) begin
            compare_value(name, "snoop line", exp_data, o_snoop_resp_data, errs);
            compare_value(name, "snoop be", line_t'(16'hffff), line_t'(o_snoop_resp_be), errs);
          end else begin
            compare_value(name, "snoop be", '0, line_t'(o_snoop_resp_be), errs);
          end
        end
      end
      "RF": begin
        for (n = 0; n < TIMEOUT_CYCLES && refill_count == refill_seen; n++) begin
          @(negedge i_clk);
        end
        if (refill_count == refill_seen) begin
          $display("%s: no refill pulse within %0d cycles", name, TIMEOUT_CYCLES);
          errs++;
        end else begin
          assert (refill_count == refill_seen + 1) else begin
            $display("%s: more than one refill pulse arrived", name);
            errs++;
          end
          compare_value(name, "refill address", line_t'(addr), line_t'(refill_paddr), errs);
          refill_seen = refill_count;
        end
      end
      "QT": begin
        repeat (QUIET_CYCLES) @(negedge i_clk);
        assert (refill_count == refill_seen) else begin
          $display("%s: a refill pulse came that no load asked for", name);
          errs++;
          refill_seen = refill_count;
        end
      end
      default: begin
        $display("%s: unknown operation %s in the trace", name, op);
        errs++;
      end
    endcase
    tests++;
    if (errs == 0) begin
      passed++;
      $display("[pass] %s", name);
    end else begin
      fails++;
      $display("[fail] %s", name);
    end
  endtask

  task automatic run_trace();
    int     fd;
    int     n;
    string  line;
    string  name;
    string  op;
    string  exp_st;
    paddr_t addr;
    word_t  st_data;
    be_t    st_be;
    line_t  exp_data;
    fd = $fopen("testbench/l1d_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/l1d_trace.txt");
      fails++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %s %h %h %h %s %h",
                    name, op, addr, st_data, st_be, exp_st, exp_data);
        if (n == 7) run_test(name, op, addr, st_data, st_be, exp_st, exp_data);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    i_reset_n     = 1'b0;
    i_ld_valid    = 1'b0;
    i_ld_paddr    = '0;
    i_st_valid    = 1'b0;
    i_st_paddr    = '0;
    i_st_data     = '0;
    i_st_be       = '0;
    i_snoop_valid = 1'b0;
    i_snoop_paddr = '0;
    void'($urandom(32'ha9804a3f));
    fork
      run_l2_model();
    join_none
    repeat (4) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);
    run_trace();
    $display("Tests run %0d, passed %0d, failed %0d", tests, passed, fails);
    if (fails == 0 && tests > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/l1d_refill_beat_counter.sv
`timescale 1ns/100ps

module l1d_refill_beat_counter (
  input  logic           i_clk,
  input  logic           i_reset_n,
  input  logic           i_start,
  input  logic           i_resp_valid,
  input  l1d_pkg::word_t i_resp_data,
  output l1d_pkg::line_t o_line,
  output logic           o_line_done
);
  import l1d_pkg::*;

  logic  r_pending;
  beat_t r_count;
  logic  r_done;
  line_t r_line;
  logic  w_beat;

  // Stray beats outside a refill are dropped
  assign w_beat = i_resp_valid & r_pending;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pending <= 1'b0;
      r_count   <= '0;
      r_done    <= 1'b0;
    end else begin
      r_done <= w_beat && (r_count == beat_t'(BEATS - 1));
      if (i_start) begin
        r_pending <= 1'b1;
        r_count   <= '0;
      end else if (w_beat) begin
        r_count <= r_count + 1'b1;
        if (r_count == beat_t'(BEATS - 1)) begin
          r_pending <= 1'b0;
        end
      end
    end
  end

  // Beats arrive in word order
  always_ff @(posedge i_clk) begin
    if (w_beat) begin
      r_line[int'(r_count) * WORD_W +: WORD_W] <= i_resp_data;
    end
  end

  assign o_line      = r_line;
  assign o_line_done = r_done;

endmodule

//--- verilog/l1d_top.sv
`timescale 1ns/100ps

module l1d_top (
  input  logic                      i_clk,
  input  logic                      i_reset_n,

  // Core load port
  input  logic                      i_ld_valid,
  input  l1d_pkg::paddr_t           i_ld_paddr,
  output logic                      o_ld_resp_valid,
  output l1d_pkg::l1d_status_e      o_ld_resp_status,
  output l1d_pkg::word_t            o_ld_resp_data,

  // Core store port
  input  logic                      i_st_valid,
  input  l1d_pkg::paddr_t           i_st_paddr,
  input  l1d_pkg::word_t            i_st_data,
  input  l1d_pkg::be_t              i_st_be,
  output logic                      o_st_resp_valid,
  output l1d_pkg::l1d_status_e      o_st_resp_status,

  // Snoop port
  input  logic                      i_snoop_valid,
  input  l1d_pkg::paddr_t           i_snoop_paddr,
  output logic                      o_snoop_resp_valid,
  output l1d_pkg::l1d_status_e      o_snoop_resp_status,
  output l1d_pkg::line_t            o_snoop_resp_data,
  output logic [l1d_pkg::LINE_W/8-1:0] o_snoop_resp_be,

  output logic                      o_refill_valid,
  output l1d_pkg::paddr_t           o_refill_paddr,

  // L2 channel
  output logic                      o_l2_req_valid,
  input  logic                      i_l2_req_ready,
  output l1d_pkg::l2_cmd_e          o_l2_req_cmd,
  output l1d_pkg::paddr_t           o_l2_req_paddr,
  output l1d_pkg::line_t            o_l2_req_data,
  input  logic                      i_l2_resp_valid,
  input  l1d_pkg::word_t            i_l2_resp_data
);
  import l1d_pkg::*;

  index_t      w_ld_index, w_st_index, w_sn_index, w_rd_a_index, w_busy_index;
  tag_t        w_ld_tag, w_st_tag, w_sn_tag, w_rd_a_tag, w_rd_b_tag, w_busy_tag;
  beat_t       w_ld_word, w_st_word;
  logic        w_rd_a_valid, w_rd_a_dirty, w_rd_b_valid;
  line_t       w_rd_a_line, w_rd_b_line, w_fill_line;
  logic        w_busy, w_miss_start, w_st_we, w_fill_we, w_line_done, w_count_start;
  logic        w_ld_hit, w_st_hit, w_sn_hit, w_st_port_ok;
  l1d_status_e w_ld_status, w_st_status;

  assign w_ld_index = i_ld_paddr[TAG_LSB-1:IDX_LSB];
  assign w_ld_tag   = i_ld_paddr[31:TAG_LSB];
  assign w_ld_word  = i_ld_paddr[IDX_LSB-1:WORD_LSB];
  assign w_st_index = i_st_paddr[TAG_LSB-1:IDX_LSB];
  assign w_st_tag   = i_st_paddr[31:TAG_LSB];
  assign w_st_word  = i_st_paddr[IDX_LSB-1:WORD_LSB];
  assign w_sn_index = i_snoop_paddr[TAG_LSB-1:IDX_LSB];
  assign w_sn_tag   = i_snoop_paddr[31:TAG_LSB];

  // --------------------------------------------------
  // s0 lookup and status
  // --------------------------------------------------
  // Port A follows the load, a store shares it only on the same set
  assign w_rd_a_index = i_ld_valid ? w_ld_index : w_st_index;
  assign w_st_port_ok = !i_ld_valid || (w_ld_index == w_st_index);
  assign w_ld_hit     = w_rd_a_valid && (w_rd_a_tag == w_ld_tag);
  assign w_st_hit     = w_rd_a_valid && (w_rd_a_tag == w_st_tag);
  assign w_sn_hit     = w_rd_b_valid && (w_rd_b_tag == w_sn_tag);

  always_comb begin
    w_ld_status  = STATUS_NONE;
    w_miss_start = 1'b0;
    if (i_ld_valid) begin
      if (w_busy && w_ld_index == w_busy_index) w_ld_status = STATUS_L1D_CONFLICT;
      else if (w_ld_hit)                        w_ld_status = STATUS_HIT;
      else if (w_busy)                          w_ld_status = STATUS_L1D_CONFLICT;
      else begin
        w_ld_status  = STATUS_MISS;
        w_miss_start = 1'b1;
      end
    end
  end

  // A store next to a starting refill would be lost at fill time
  always_comb begin
    w_st_status = STATUS_NONE;
    w_st_we     = 1'b0;
    if (i_st_valid) begin
      if (w_busy || w_miss_start || !w_st_port_ok) w_st_status = STATUS_L1D_CONFLICT;
      else if (w_st_hit) begin
        w_st_status = STATUS_HIT;
        w_st_we     = 1'b1;
      end else begin
        w_st_status = STATUS_MISS;
      end
    end
  end

  // --------------------------------------------------
  // s1 response registers
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ld_resp_valid     <= 1'b0;
      o_st_resp_valid     <= 1'b0;
      o_snoop_resp_valid  <= 1'b0;
      o_ld_resp_status    <= STATUS_NONE;
      o_st_resp_status    <= STATUS_NONE;
      o_snoop_resp_status <= STATUS_NONE;
    end else begin
      o_ld_resp_valid     <= i_ld_valid;
      o_st_resp_valid     <= i_st_valid;
      o_snoop_resp_valid  <= i_snoop_valid;
      o_ld_resp_status    <= w_ld_status;
      o_st_resp_status    <= w_st_status;
      o_snoop_resp_status <= !i_snoop_valid ? STATUS_NONE :
                             w_sn_hit       ? STATUS_HIT : STATUS_MISS;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ld_resp_data    <= w_rd_a_line[int'(w_ld_word) * WORD_W +: WORD_W];
    o_snoop_resp_data <= w_rd_b_line;
    o_snoop_resp_be   <= (i_snoop_valid && w_sn_hit) ? '1 : '0;
  end

  l1d_data_array l1d_data_array_inst (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_rd_a_index (w_rd_a_index),
    .o_rd_a_tag   (w_rd_a_tag),
    .o_rd_a_valid (w_rd_a_valid),
    .o_rd_a_dirty (w_rd_a_dirty),
    .o_rd_a_line  (w_rd_a_line),
    .i_rd_b_index (w_sn_index),
    .o_rd_b_tag   (w_rd_b_tag),
    .o_rd_b_valid (w_rd_b_valid),
    .o_rd_b_line  (w_rd_b_line),
    .i_st_we      (w_st_we),
    .i_st_index   (w_st_index),
    .i_st_word    (w_st_word),
    .i_st_data    (i_st_data),
    .i_st_be      (i_st_be),
    .i_fill_we    (w_fill_we),
    .i_fill_index (w_busy_index),
    .i_fill_tag   (w_busy_tag),
    .i_fill_line  (w_fill_line)
  );

  l1d_miss_fsm l1d_miss_fsm_inst (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_miss_start   (w_miss_start),
    .i_miss_paddr   (i_ld_paddr),
    .i_victim_valid (w_rd_a_valid),
    .i_victim_dirty (w_rd_a_dirty),
    .i_victim_tag   (w_rd_a_tag),
    .i_victim_line  (w_rd_a_line),
    .o_busy         (w_busy),
    .o_busy_index   (w_busy_index),
    .o_busy_tag     (w_busy_tag),
    .o_l2_req_valid (o_l2_req_valid),
    .i_l2_req_ready (i_l2_req_ready),
    .o_l2_req_cmd   (o_l2_req_cmd),
    .o_l2_req_paddr (o_l2_req_paddr),
    .o_l2_req_data  (o_l2_req_data),
    .i_line_done    (w_line_done),
    .o_count_start  (w_count_start),
    .o_fill_we      (w_fill_we),
    .o_refill_valid (o_refill_valid),
    .o_refill_paddr (o_refill_paddr)
  );

  l1d_refill_beat_counter l1d_refill_beat_counter_inst (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_start      (w_count_start),
    .i_resp_valid (i_l2_resp_valid),
    .i_resp_data  (i_l2_resp_data),
    .o_line       (w_fill_line),
    .o_line_done  (w_line_done)
  );

endmodule
